//--- source/snd_params.svh
`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// Channel count and sample width
`define SND_NUM_CH    4
`define SND_SAMPLE_W  20

// Channel n owns four bytes starting at SND_ADDR_CH0 + 4n
`define SND_ADDR_CH0  16'hFF10

// Mixer and master control
`define SND_ADDR_NR50 16'hFF24
`define SND_ADDR_NR51 16'hFF25
`define SND_ADDR_NR52 16'hFF26

`endif

//--- source/snd_pkg.sv
`include "snd_params.svh"

package snd_pkg;

   // Register slot inside one channel's four-byte window
   typedef enum logic [1:0] {
      REG_DUTY_LEN     = 2'd0,  // Duty in 7:6, length in 5:0
      REG_VOLUME       = 2'd1,  // Volume in 7:4
      REG_FREQ_LO      = 2'd2,
      REG_CTRL_FREQ_HI = 2'd3   // Trigger 7, length enable 6, freq high 2:0
   } reg_sel_e;

   // High for the first 1, 2, 4 or 6 of the 8 steps
   typedef enum logic [1:0] {
      DUTY_12 = 2'd0,
      DUTY_25 = 2'd1,
      DUTY_50 = 2'd2,
      DUTY_75 = 2'd3
   } duty_e;

   typedef struct packed {
      duty_e       duty;
      logic [5:0]  length;
      logic [3:0]  volume;
      logic [10:0] freq;
      logic        length_en;
      logic        trigger;       // One-cycle pulse
      logic        load_length;   // One-cycle pulse
   } chan_cfg_t;

   typedef struct packed {
      logic [`SND_NUM_CH-1:0] route_so1;
      logic [`SND_NUM_CH-1:0] route_so2;
      logic                   so1_on;   // NR50 bit 3
      logic                   so2_on;   // NR50 bit 7
   } mix_cfg_t;

endpackage

//--- source/snd_reg_file.sv
`include "snd_params.svh"

module snd_reg_file
   import snd_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [15:0]            addr,
   input  logic [7:0]             wdata,
   input  logic                   we,
   input  logic                   re,
   input  logic [`SND_NUM_CH-1:0] chan_on,
   output logic [7:0]             rdata,
   output chan_cfg_t              chan_cfg [`SND_NUM_CH],
   output mix_cfg_t               mix_cfg,
   output logic                   master_en
);

   localparam int CH_W = $clog2(`SND_NUM_CH);

   logic [7:0]             ch_regs [`SND_NUM_CH][4];  // Raw channel bytes
   logic [7:0]             nr50;
   logic [7:0]             nr51;
   logic [`SND_NUM_CH-1:0] trig_q;
   logic [`SND_NUM_CH-1:0] load_q;

   logic [15:0]     offset;
   logic            ch_hit;
   logic [CH_W-1:0] ch_idx;
   reg_sel_e        slot;
   logic [7:0]      rd_byte;

   // Address decode
   assign offset = addr - `SND_ADDR_CH0;
   assign ch_hit = (addr >= `SND_ADDR_CH0) &&
                   (addr < (`SND_ADDR_CH0 + 4 * `SND_NUM_CH));
   assign ch_idx = offset[CH_W+1:2];
   assign slot   = reg_sel_e'(offset[1:0]);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         master_en <= 1'b0;
         nr50      <= '0;
         nr51      <= '0;
         ch_regs   <= '{default: '0};
         trig_q    <= '0;
         load_q    <= '0;
      end else begin
         trig_q <= '0;
         load_q <= '0;
         if (we && addr == `SND_ADDR_NR52) begin
            master_en <= wdata[7];
            if (!wdata[7]) begin
               // Powering down wipes every setting
               nr50    <= '0;
               nr51    <= '0;
               ch_regs <= '{default: '0};
            end
         end else if (we && master_en) begin  // Locked while powered down
            if (addr == `SND_ADDR_NR50)
               nr50 <= wdata;
            if (addr == `SND_ADDR_NR51)
               nr51 <= wdata;
            if (ch_hit) begin
               case (slot)
                  REG_DUTY_LEN: begin
                     ch_regs[ch_idx][slot] <= wdata;
                     load_q[ch_idx]        <= 1'b1;
                  end
                  REG_CTRL_FREQ_HI: begin
                     ch_regs[ch_idx][slot] <= {1'b0, wdata[6:0]};  // Trigger is write only
                     trig_q[ch_idx]        <= wdata[7];
                  end
                  default: ch_regs[ch_idx][slot] <= wdata;
               endcase
            end
         end
      end
   end

   // Unpack the stored bytes into channel fields
   always_comb begin
      for (int c = 0; c < `SND_NUM_CH; c++) begin
         chan_cfg[c].duty        = duty_e'(ch_regs[c][REG_DUTY_LEN][7:6]);
         chan_cfg[c].length      = ch_regs[c][REG_DUTY_LEN][5:0];
         chan_cfg[c].volume      = ch_regs[c][REG_VOLUME][7:4];
         chan_cfg[c].freq        = {ch_regs[c][REG_CTRL_FREQ_HI][2:0],
                                    ch_regs[c][REG_FREQ_LO]};
         chan_cfg[c].length_en   = ch_regs[c][REG_CTRL_FREQ_HI][6];
         chan_cfg[c].trigger     = trig_q[c];
         chan_cfg[c].load_length = load_q[c];
      end
   end

   assign mix_cfg.route_so1 = nr51[`SND_NUM_CH-1:0];
   assign mix_cfg.route_so2 = nr51[`SND_NUM_CH+3:4];
   assign mix_cfg.so1_on    = nr50[3];
   assign mix_cfg.so2_on    = nr50[7];

   always_comb begin
      rd_byte = 8'hFF;  // Unmapped
      if (ch_hit)
         rd_byte = ch_regs[ch_idx][slot];
      else if (addr == `SND_ADDR_NR50)
         rd_byte = nr50;
      else if (addr == `SND_ADDR_NR51)
         rd_byte = nr51;
      else if (addr == `SND_ADDR_NR52)
         rd_byte = {master_en, {(7 - `SND_NUM_CH){1'b1}}, chan_on};
   end

   // Read data is held until the next read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rdata <= '0;
      else if (re)
         rdata <= rd_byte;
   end

endmodule

//--- source/snd_tone_channel.sv
`include "snd_params.svh"

module snd_tone_channel
   import snd_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     master_en,
   input  logic                     sample_strobe,
   input  chan_cfg_t                cfg,
   output logic                     on,
   output logic [`SND_SAMPLE_W-1:0] sample
);

   typedef enum logic {
      ST_OFF  = 1'b0,
      ST_PLAY = 1'b1
   } state_e;

   state_e      state;
   logic [11:0] timer;      // Counts down one step period
   logic [2:0]  step;
   logic [6:0]  len_cnt;
   logic [11:0] period;
   logic [6:0]  len_load;
   logic        duty_high;

   assign period   = 12'd2048 - {1'b0, cfg.freq};
   assign len_load = 7'd64 - {1'b0, cfg.length};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ST_OFF;
         timer   <= '0;
         step    <= '0;
         len_cnt <= '0;
      end else if (!master_en) begin
         state   <= ST_OFF;
         timer   <= '0;
         step    <= '0;
         len_cnt <= '0;
      end else begin
         if (cfg.trigger) begin
            state   <= ST_PLAY;
            step    <= '0;
            timer   <= period;
            len_cnt <= len_load;
         end else if (state == ST_PLAY) begin
            if (timer == 12'd1) begin
               timer <= period;  // Picks up a new freq at the period boundary
               step  <= step + 3'd1;
            end else begin
               timer <= timer - 12'd1;
            end
            // Length runs on the codec sample rate
            if (cfg.length_en && sample_strobe && len_cnt != '0) begin
               len_cnt <= len_cnt - 7'd1;
               if (len_cnt == 7'd1)
                  state <= ST_OFF;
            end
         end
         if (cfg.load_length && !cfg.trigger)
            len_cnt <= len_load;
      end
   end

   always_comb begin
      case (cfg.duty)
         DUTY_12: duty_high = (step == 3'd0);
         DUTY_25: duty_high = (step < 3'd2);
         DUTY_50: duty_high = (step < 3'd4);
         DUTY_75: duty_high = (step < 3'd6);
         default: duty_high = 1'b0;
      endcase
   end

   assign on = (state == ST_PLAY) && master_en;

   // Volume sits in the top nibble of the sample
   assign sample = (on && duty_high) ?
                   {cfg.volume, {(`SND_SAMPLE_W - 4){1'b0}}} : '0;

endmodule

//--- source/snd_mixer.sv
`include "snd_params.svh"

module snd_mixer
   import snd_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     sample_strobe,
   input  logic                     master_en,
   input  mix_cfg_t                 mix_cfg,
   input  logic [`SND_SAMPLE_W-1:0] chan_sample [`SND_NUM_CH],
   output logic [`SND_SAMPLE_W-1:0] so1_sample,
   output logic [`SND_SAMPLE_W-1:0] so2_sample,
   output logic                     sample_valid
);

   logic [`SND_SAMPLE_W-1:0] so1_sum;
   logic [`SND_SAMPLE_W-1:0] so2_sum;

   // Quarter scale per channel so four full channels cannot overflow
   always_comb begin
      so1_sum = '0;
      so2_sum = '0;
      for (int c = 0; c < `SND_NUM_CH; c++) begin
         if (mix_cfg.route_so1[c])
            so1_sum = so1_sum + (chan_sample[c] >> 2);
         if (mix_cfg.route_so2[c])
            so2_sum = so2_sum + (chan_sample[c] >> 2);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         so1_sample   <= '0;
         so2_sample   <= '0;
         sample_valid <= 1'b0;
      end else begin
         sample_valid <= sample_strobe;
         if (sample_strobe) begin
            so1_sample <= (mix_cfg.so1_on && master_en) ? so1_sum : '0;
            so2_sample <= (mix_cfg.so2_on && master_en) ? so2_sum : '0;
         end
      end
   end

endmodule

//--- source/snd_controller.sv
`include "snd_params.svh"

module snd_controller
   import snd_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [15:0]              addr,
   input  logic [7:0]               wdata,
   input  logic                     we,
   input  logic                     re,
   input  logic                     sample_strobe,
   output logic [7:0]               rdata,
   output logic [`SND_SAMPLE_W-1:0] so1_sample,
   output logic [`SND_SAMPLE_W-1:0] so2_sample,
   output logic                     sample_valid
);

   chan_cfg_t                chan_cfg    [`SND_NUM_CH];
   logic [`SND_SAMPLE_W-1:0] chan_sample [`SND_NUM_CH];
   logic [`SND_NUM_CH-1:0]   chan_on;
   mix_cfg_t                 mix_cfg;
   logic                     master_en;

   snd_reg_file u_reg_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .wdata     (wdata),
      .we        (we),
      .re        (re),
      .chan_on   (chan_on),
      .rdata     (rdata),
      .chan_cfg  (chan_cfg),
      .mix_cfg   (mix_cfg),
      .master_en (master_en)
   );

   // Four identical square channels
   for (genvar g = 0; g < `SND_NUM_CH; g++) begin : g_chan
      snd_tone_channel u_chan (
         .clk           (clk),
         .rst_n         (rst_n),
         .master_en     (master_en),
         .sample_strobe (sample_strobe),
         .cfg           (chan_cfg[g]),
         .on            (chan_on[g]),
         .sample        (chan_sample[g])
      );
   end

   snd_mixer u_mixer (
      .clk           (clk),
      .rst_n         (rst_n),
      .sample_strobe (sample_strobe),
      .master_en     (master_en),
      .mix_cfg       (mix_cfg),
      .chan_sample   (chan_sample),
      .so1_sample    (so1_sample),
      .so2_sample    (so2_sample),
      .sample_valid  (sample_valid)
   );

endmodule

//--- test/tb_snd_controller.sv
`include "snd_params.svh"

module tb_snd_controller
   import snd_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   typedef enum logic [1:0] {
      OP_WRITE,
      OP_READ,
      OP_STROBE,
      OP_WAIT
   } op_e;

   typedef struct packed {
      op_e         op;
      logic [15:0] addr;
      logic [7:0]  data;
      logic [7:0]  exp_val;      // Expected byte of a read
      logic [15:0] wait_cycles;
   } op_row_t;

   logic                     clk;
   logic                     rst_n;
   logic [15:0]              addr;
   logic [7:0]               wdata;
   logic                     we;
   logic                     re;
   logic                     sample_strobe;
   logic [7:0]               rdata;
   logic [`SND_SAMPLE_W-1:0] so1_sample;
   logic [`SND_SAMPLE_W-1:0] so2_sample;
   logic                     sample_valid;

   op_row_t table_q [$];
   int      cyc = 0;
   int      cycle_limit = 0;
   int      err_cnt = 0;

   // Reference model of the register map and the channels
   logic [7:0] m_regs   [`SND_NUM_CH][4];
   logic [7:0] m_nr50;
   logic [7:0] m_nr51;
   logic       m_master;
   logic       m_active [`SND_NUM_CH];
   int         m_start  [`SND_NUM_CH];  // Cycle where step 0 begins
   int         m_len    [`SND_NUM_CH];

   snd_controller UUT (
      .clk           (clk),
      .rst_n         (rst_n),
      .addr          (addr),
      .wdata         (wdata),
      .we            (we),
      .re            (re),
      .sample_strobe (sample_strobe),
      .rdata         (rdata),
      .so1_sample    (so1_sample),
      .so2_sample    (so2_sample),
      .sample_valid  (sample_valid)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cycle_limit > 0 && cyc >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display(">>> FAIL");
         $finish;
      end
   end

   function automatic void model_reset();
      m_regs   = '{default: '0};
      m_nr50   = '0;
      m_nr51   = '0;
      m_master = 1'b0;
      for (int c = 0; c < `SND_NUM_CH; c++) begin
         m_active[c] = 1'b0;
         m_start[c]  = 0;
         m_len[c]    = 0;
      end
   endfunction

   function automatic void model_write(input logic [15:0] a, input logic [7:0] d, input int now);
      int       off;
      int       c;
      reg_sel_e s;
      off = int'(a) - int'(`SND_ADDR_CH0);
      c   = off / 4;
      s   = reg_sel_e'(off[1:0]);
      if (a == `SND_ADDR_NR52) begin
         m_master = d[7];
         if (!d[7])
            model_reset();
      end else if (m_master) begin
         if (a == `SND_ADDR_NR50)
            m_nr50 = d;
         else if (a == `SND_ADDR_NR51)
            m_nr51 = d;
         else if (off >= 0 && off < 4 * `SND_NUM_CH) begin
            if (s == REG_CTRL_FREQ_HI) begin
               m_regs[c][s] = {1'b0, d[6:0]};
               if (d[7]) begin
                  m_active[c] = 1'b1;
                  m_start[c]  = now + 2;  // Pulse cycle, then the channel starts
                  m_len[c]    = 64 - int'(m_regs[c][REG_DUTY_LEN][5:0]);
               end
            end else begin
               m_regs[c][s] = d;
               if (s == REG_DUTY_LEN)
                  m_len[c] = 64 - int'(d[5:0]);
            end
         end
      end
   endfunction

   // Square level of one channel from the cycles elapsed since its trigger
   function automatic logic [`SND_SAMPLE_W-1:0] chan_level(input int c, input int now);
      logic [`SND_SAMPLE_W-1:0] level;
      int                       period;
      int                       step;
      int                       high_steps;
      level  = '0;
      period = 2048 - int'({m_regs[c][REG_CTRL_FREQ_HI][2:0], m_regs[c][REG_FREQ_LO]});
      if (!m_master || !m_active[c] || now < m_start[c])
         return level;
      step = ((now - m_start[c]) / period) % 8;
      case (duty_e'(m_regs[c][REG_DUTY_LEN][7:6]))
         DUTY_12: high_steps = 1;
         DUTY_25: high_steps = 2;
         DUTY_50: high_steps = 4;
         default: high_steps = 6;
      endcase
      if (step < high_steps)
         level[19:16] = m_regs[c][REG_VOLUME][7:4];
      return level;
   endfunction

   function automatic logic [`SND_SAMPLE_W-1:0] expected_out(input logic right, input int now);
      logic [`SND_SAMPLE_W-1:0] sum;
      logic [`SND_NUM_CH-1:0]   route;
      logic                     enable;
      sum    = '0;
      route  = right ? m_nr51[7:4] : m_nr51[3:0];
      enable = right ? m_nr50[7] : m_nr50[3];
      for (int c = 0; c < `SND_NUM_CH; c++) begin
         if (route[c])
            sum = sum + (chan_level(c, now) >> 2);
      end
      return (enable && m_master) ? sum : '0;
   endfunction

   function automatic void length_tick(input int now);
      for (int c = 0; c < `SND_NUM_CH; c++) begin
         if (m_master && m_active[c] && now >= m_start[c] &&
             m_regs[c][REG_CTRL_FREQ_HI][6] && m_len[c] > 0) begin
            m_len[c]--;
            if (m_len[c] == 0)
               m_active[c] = 1'b0;
         end
      end
   endfunction

   function automatic void push_row(input op_e op, input logic [15:0] a, input logic [7:0] d,
                                    input logic [7:0] e, input int n);
      op_row_t row;
      row.op          = op;
      row.addr        = a;
      row.data        = d;
      row.exp_val     = e;
      row.wait_cycles = 16'(n);
      table_q.push_back(row);
   endfunction

   function automatic void add_write(input logic [15:0] a, input logic [7:0] d);
      push_row(OP_WRITE, a, d, 8'h00, 0);
   endfunction

   function automatic void add_read(input logic [15:0] a, input logic [7:0] e);
      push_row(OP_READ, a, 8'h00, e, 0);
   endfunction

   function automatic logic [15:0] ch_addr(input int c, input reg_sel_e s);
      return 16'(`SND_ADDR_CH0 + 4 * c + int'(s));
   endfunction

   function automatic void build_table();
      logic [3:0] vol;
      add_read(`SND_ADDR_NR52, 8'h70);  // Power-on state
      push_row(OP_STROBE, 16'h0, 8'h00, 8'h00, 0);
      add_write(`SND_ADDR_NR50, 8'h77);  // Locked while master is off
      add_read(`SND_ADDR_NR50, 8'h00);
      add_write(`SND_ADDR_NR52, 8'h80);
      add_read(`SND_ADDR_NR52, 8'hF0);
      add_write(`SND_ADDR_NR50, 8'h5A);
      add_read(`SND_ADDR_NR50, 8'h5A);
      add_write(`SND_ADDR_NR51, 8'hC3);
      add_read(`SND_ADDR_NR51, 8'hC3);
      for (int c = 0; c < `SND_NUM_CH; c++) begin
         add_write(ch_addr(c, REG_VOLUME), 8'(8'h97 + c));
         add_read(ch_addr(c, REG_VOLUME), 8'(8'h97 + c));
         add_write(ch_addr(c, REG_FREQ_LO), 8'(8'h21 + 16 * c));
         add_read(ch_addr(c, REG_FREQ_LO), 8'(8'h21 + 16 * c));
      end
      add_read(16'hFF27, 8'hFF);
      add_read(16'hFF0F, 8'hFF);
      // Channel 0 alone at freq 0, then the other duties
      add_write(`SND_ADDR_NR50, 8'h88);
      add_write(`SND_ADDR_NR51, 8'h11);
      for (int c = 0; c < `SND_NUM_CH; c++) begin
         add_write(ch_addr(c, REG_DUTY_LEN), {duty_e'(c), 6'd0});
         add_write(ch_addr(c, REG_VOLUME), 8'(8'hA0 + 8'h10 * c));
         add_write(ch_addr(c, REG_FREQ_LO), 8'h00);
         add_write(ch_addr(c, REG_CTRL_FREQ_HI), 8'h80);
         if (c == 0) begin
            push_row(OP_WAIT, 16'h0, 8'h00, 8'h00, 2);
            push_row(OP_STROBE, 16'h0, 8'h00, 8'h00, 0);
            add_read(`SND_ADDR_NR52, 8'hF1);
         end
      end
      add_write(`SND_ADDR_NR51, 8'hFF);
      push_row(OP_WAIT, 16'h0, 8'h00, 8'h00, 2);
      push_row(OP_STROBE, 16'h0, 8'h00, 8'h00, 0);
      add_read(`SND_ADDR_NR52, 8'hFF);
      push_row(OP_WAIT, 16'h0, 8'h00, 8'h00, 14400);  // Into step 7 at freq 0
      push_row(OP_STROBE, 16'h0, 8'h00, 8'h00, 0);
      // Random volumes and routing, all channels back at step 0
      for (int c = 0; c < `SND_NUM_CH; c++) begin
         vol = 4'(1 + $urandom % 15);
         add_write(ch_addr(c, REG_VOLUME), {vol, 4'h0});
         add_write(ch_addr(c, REG_CTRL_FREQ_HI), 8'h80);
      end
      add_write(`SND_ADDR_NR51, 8'($urandom) | 8'h11);  // Channel 0 feeds both outputs
      push_row(OP_WAIT, 16'h0, 8'h00, 8'h00, 2);
      push_row(OP_STROBE, 16'h0, 8'h00, 8'h00, 0);
      add_write(`SND_ADDR_NR50, 8'h80);  // SO1 off
      push_row(OP_STROBE, 16'h0, 8'h00, 8'h00, 0);
      // Length of 60 on channel 2 expires after four strobes
      add_write(`SND_ADDR_NR50, 8'h88);
      add_write(`SND_ADDR_NR51, 8'h44);
      add_write(ch_addr(2, REG_VOLUME), 8'hC0);
      add_write(ch_addr(2, REG_DUTY_LEN), {DUTY_50, 6'd60});
      add_write(ch_addr(2, REG_CTRL_FREQ_HI), 8'hC0);
      push_row(OP_WAIT, 16'h0, 8'h00, 8'h00, 2);
      for (int i = 0; i < 3; i++)
         push_row(OP_STROBE, 16'h0, 8'h00, 8'h00, 0);
      add_read(`SND_ADDR_NR52, 8'hFF);
      push_row(OP_STROBE, 16'h0, 8'h00, 8'h00, 0);
      add_read(`SND_ADDR_NR52, 8'hFB);
      push_row(OP_STROBE, 16'h0, 8'h00, 8'h00, 0);
      // Master off wipes everything
      add_write(`SND_ADDR_NR52, 8'h00);
      push_row(OP_STROBE, 16'h0, 8'h00, 8'h00, 0);
      add_read(`SND_ADDR_NR52, 8'h70);
      add_read(`SND_ADDR_NR50, 8'h00);
      add_read(`SND_ADDR_NR51, 8'h00);
      for (int c = 0; c < `SND_NUM_CH; c++) begin
         add_read(ch_addr(c, REG_VOLUME), 8'h00);
         add_read(ch_addr(c, REG_FREQ_LO), 8'h00);
      end
      add_write(ch_addr(1, REG_VOLUME), 8'hF0);
      add_read(ch_addr(1, REG_VOLUME), 8'h00);
   endfunction

   function automatic int table_cycles();
      int total;
      total = 0;
      foreach (table_q[i])
         total += (table_q[i].op == OP_WAIT) ? int'(table_q[i].wait_cycles) :
                  (table_q[i].op == OP_STROBE) ? 2 : 1;
      return total;
   endfunction

   task automatic run_row(input op_row_t row);
      logic [`SND_SAMPLE_W-1:0] exp1;
      logic [`SND_SAMPLE_W-1:0] exp2;
      int                       waited;
      case (row.op)
         OP_WRITE: begin
            addr  = row.addr;
            wdata = row.data;
            we    = 1'b1;
            model_write(row.addr, row.data, cyc);
            @(negedge clk);
            we = 1'b0;
         end
         OP_READ: begin
            addr = row.addr;
            re   = 1'b1;
            @(negedge clk);
            re = 1'b0;
            assert (rdata == row.exp_val) else begin
               err_cnt++;
               $display("mismatch at %0t: read of %h gave %h, expected %h",
                        $time, row.addr, rdata, row.exp_val);
            end
         end
         OP_STROBE: begin
            exp1 = expected_out(1'b0, cyc);  // Levels seen at the capture edge
            exp2 = expected_out(1'b1, cyc);
            length_tick(cyc);
            sample_strobe = 1'b1;
            @(negedge clk);
            sample_strobe = 1'b0;
            waited = 0;
            while (!sample_valid && waited < 4) begin
               @(negedge clk);
               waited++;
            end
            assert (sample_valid) else begin
               err_cnt++;
               $display("sample_valid did not rise after the strobe, time %0t", $time);
            end
            assert (so1_sample == exp1) else begin
               err_cnt++;
               $display("mismatch at %0t: SO1 is %h, expected %h", $time, so1_sample, exp1);
            end
            assert (so2_sample == exp2) else begin
               err_cnt++;
               $display("mismatch at %0t: SO2 is %h, expected %h", $time, so2_sample, exp2);
            end
            @(negedge clk);
            assert (!sample_valid) else begin
               err_cnt++;
               $display("sample_valid stayed high longer than one cycle, time %0t", $time);
            end
         end
         default: repeat (row.wait_cycles) @(negedge clk);
      endcase
   endtask

   initial begin
      rst_n         = 1'b0;
      addr          = '0;
      wdata         = '0;
      we            = 1'b0;
      re            = 1'b0;
      sample_strobe = 1'b0;
      void'($urandom(82797));
      model_reset();
      build_table();
      cycle_limit = 2 * table_cycles() + 200;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      foreach (table_q[i])
         run_row(table_q[i]);
      $display("Ran %0d table rows, %0d errors", table_q.size(), err_cnt);
      if (err_cnt == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- sources.f
+incdir+source
source/snd_pkg.sv
source/snd_reg_file.sv
source/snd_tone_channel.sv
source/snd_mixer.sv
source/snd_controller.sv
test/tb_snd_controller.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_snd_controller \
   -f sources.f -o tb_snd_controller \
   && ./obj_dir/tb_snd_controller | tee /dev/stderr | grep -q ">>> PASS" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
